/* snes_cart_pkg.sv */
package snes_cart_pkg;

	// ==============================
	// Download port
	// ==============================

	typedef struct packed {
		logic        download;
		logic        code_index;
		logic [24:0] addr;
		logic [15:0] data;
		logic        wr;
	} dl_bus_t;

	// Header location as chosen in the menu
	typedef enum logic [2:0] {
		mode_auto,
		mode_no_header,
		mode_lorom,
		mode_hirom,
		mode_exhirom
	} header_mode_e;

	typedef struct packed {
		logic [7:0]  rom_type;
		logic [23:0] rom_mask;
		logic [23:0] ram_mask;
		logic        region;
	} cart_info_t;

	// Valid sits on top, the four words follow in big-endian field order
	typedef struct packed {
		logic        valid;
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} gg_code_t;

	// ==============================
	// Backup RAM and SD block port
	// ==============================

	typedef struct packed {
		logic        en;
		logic        we;
		logic [19:0] addr;
		logic [7:0]  data;
	} bsram_req_t;

	typedef struct packed {
		logic        ack;
		logic [7:0]  buff_addr;
		logic [15:0] buff_dout;
		logic        buff_wr;
	} sd_blk_t;

	typedef enum logic [1:0] {
		bk_idle,
		bk_request,
		bk_transfer
	} bk_state_e;

	// Copier prefix in front of the ROM image, in bytes
	localparam int COPIER_OFFSET = 512;

	// Internal header size byte, RAM size byte sits two bytes further
	localparam logic [15:0] HDR_LOROM_SIZE   = 16'h7FD6;
	localparam logic [15:0] HDR_HIROM_SIZE   = 16'hFFD6;
	localparam logic [23:0] HDR_EXHIROM_SIZE = 24'h40FFD6;

	localparam logic [3:0] DEFAULT_ROM_SIZE = 4'hC;

endpackage

/* cart_header_detect.sv */
module cart_header_detect (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  snes_cart_pkg::dl_bus_t      dl,
	input  snes_cart_pkg::header_mode_e header_mode,
	output snes_cart_pkg::cart_info_t   cart_info
);

	logic        cart_wr;
	logic        hdr_forced;
	logic [23:0] size_base;
	logic [24:0] size_addr;
	logic [24:0] ram_addr;
	logic [3:0]  rom_size;
	logic [3:0]  ram_size;

	assign cart_wr = dl.download & ~dl.code_index & dl.wr;

	// Location of the internal header for the forced modes
	always_comb begin
		hdr_forced = 1'b1;
		size_base = '0;
		case (header_mode)
			snes_cart_pkg::mode_lorom:   size_base = {8'h00, snes_cart_pkg::HDR_LOROM_SIZE};
			snes_cart_pkg::mode_hirom:   size_base = {8'h00, snes_cart_pkg::HDR_HIROM_SIZE};
			snes_cart_pkg::mode_exhirom: size_base = snes_cart_pkg::HDR_EXHIROM_SIZE;
			default:                     hdr_forced = 1'b0;
		endcase
	end

	assign size_addr = {1'b0, size_base} + 25'(snes_cart_pkg::COPIER_OFFSET);
	assign ram_addr = size_addr + 25'd2;

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_size <= snes_cart_pkg::DEFAULT_ROM_SIZE;
			ram_size <= 4'h0;
			cart_info <= '0;
		end else if (cart_wr) begin
			if (dl.addr == 25'd0) begin
				rom_size <= snes_cart_pkg::DEFAULT_ROM_SIZE;
				ram_size <= 4'h0;
				// Loader prefix word carries the sizes in auto mode
				if (header_mode == snes_cart_pkg::mode_auto && dl.data[7:0] != 8'h00) begin
					{ram_size, rom_size} <= dl.data[7:0];
				end
				case (header_mode)
					snes_cart_pkg::mode_no_header: cart_info.rom_type <= 8'd0;
					snes_cart_pkg::mode_lorom:     cart_info.rom_type <= 8'd0;
					snes_cart_pkg::mode_hirom:     cart_info.rom_type <= 8'd1;
					snes_cart_pkg::mode_exhirom:   cart_info.rom_type <= 8'd2;
					default:                       cart_info.rom_type <= dl.data[15:8];
				endcase
			end

			if (dl.addr == 25'd2) begin
				cart_info.region <= dl.data[8];
			end

			if (hdr_forced && dl.addr == size_addr) begin
				rom_size <= dl.data[11:8];
			end
			if (hdr_forced && dl.addr == ram_addr) begin
				ram_size <= dl.data[3:0];
			end

			// Masks follow the size codes one write later
			cart_info.rom_mask <= (24'd1024 << rom_size) - 24'd1;
			if (ram_size != 4'h0) begin
				cart_info.ram_mask <= (24'd1024 << ram_size) - 24'd1;
			end else begin
				cart_info.ram_mask <= 24'd0;
			end
		end
	end

endmodule

/* cheat_code_loader.sv */
module cheat_code_loader (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  snes_cart_pkg::dl_bus_t  dl,
	output snes_cart_pkg::gg_code_t gg_code
);

	logic        code_wr;
	logic [24:0] code_addr;

	assign code_wr = dl.download & dl.code_index & dl.wr;

	// Code files carry the same copier prefix as cartridges
	assign code_addr = dl.addr - 25'(snes_cart_pkg::COPIER_OFFSET);

	// Valid pulses once per record, after its last word
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			gg_code.valid <= 1'b0;
		end else begin
			gg_code.valid <= code_wr && code_addr[3:0] == 4'd14;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (code_addr[3:0])
				4'd0:  gg_code.flags[15:0]    <= dl.data;
				4'd2:  gg_code.flags[31:16]   <= dl.data;
				4'd4:  gg_code.address[15:0]  <= dl.data;
				4'd6:  gg_code.address[31:16] <= dl.data;
				4'd8:  gg_code.compare[15:0]  <= dl.data;
				4'd10: gg_code.compare[31:16] <= dl.data;
				4'd12: gg_code.replace[15:0]  <= dl.data;
				4'd14: gg_code.replace[31:16] <= dl.data;
				default: ;
			endcase
		end
	end

endmodule

/* backup_sequencer.sv */
module backup_sequencer #(
	parameter int bsram_bits = 17
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  snes_cart_pkg::dl_bus_t    dl,
	input  logic [23:0]               ram_mask,
	input  logic                      console_write,
	input  logic                      bk_load,
	input  logic                      bk_save,
	input  logic                      autosave,
	input  logic                      osd_status,
	input  logic                      img_mounted,
	input  logic                      img_readonly,
	input  logic                      img_size_nz,
	input  snes_cart_pkg::sd_blk_t    sd,
	output logic [31:0]               sd_lba,
	output logic                      sd_rd,
	output logic                      sd_wr,
	output snes_cart_pkg::bsram_req_t sd_req,
	output logic                      bk_ena,
	output logic                      bk_pending,
	output logic                      bk_loading
);

	snes_cart_pkg::bk_state_e state;

	logic                  cart_download;
	logic                  old_download;
	logic                  load_req, save_req;
	logic                  old_load, old_save, old_ack;
	logic                  load_edge, save_edge;
	logic                  sd_active;
	logic [bsram_bits-2:0] word_addr;
	logic                  hold_valid;
	logic [bsram_bits-2:0] hold_addr;
	logic [7:0]            hold_data;

	assign cart_download = dl.download & ~dl.code_index;

	assign load_req = bk_load & bk_ena;
	assign save_req = (bk_save | (bk_pending & osd_status & autosave)) & bk_ena;
	assign load_edge = load_req & ~old_load;
	assign save_edge = save_req & ~old_save;

	// ==============================
	// Enable and pending flag
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			old_download <= 1'b0;
			bk_ena <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			old_download <= cart_download;
			if (!old_download && cart_download) begin
				bk_ena <= 1'b0;
			end
			// Save image is mounted by the end of the download
			if (cart_download && img_mounted && !img_readonly) begin
				bk_ena <= |ram_mask;
			end
			if (bk_ena && !osd_status && console_write) begin
				bk_pending <= 1'b1;
			end else if (state != snes_cart_pkg::bk_idle) begin
				bk_pending <= 1'b0;
			end
		end
	end

	// ==============================
	// Block walk
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			state <= snes_cart_pkg::bk_idle;
			sd_lba <= '0;
			sd_rd <= 1'b0;
			sd_wr <= 1'b0;
			bk_loading <= 1'b0;
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_ack <= 1'b0;
		end else begin
			old_load <= load_req;
			old_save <= save_req;
			old_ack <= sd.ack;
			case (state)
				snes_cart_pkg::bk_idle: begin
					if (load_edge || save_edge) begin
						state <= snes_cart_pkg::bk_request;
						bk_loading <= load_edge;
						sd_lba <= '0;
						sd_rd <= load_edge;
						sd_wr <= ~load_edge;
					end else if (old_download && !cart_download && img_size_nz && bk_ena) begin
						// Restore the save file right after a cartridge load
						state <= snes_cart_pkg::bk_request;
						bk_loading <= 1'b1;
						sd_lba <= '0;
						sd_rd <= 1'b1;
						sd_wr <= 1'b0;
					end
				end
				snes_cart_pkg::bk_request: begin
					if (sd.ack && !old_ack) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= snes_cart_pkg::bk_transfer;
					end
				end
				default: begin
					if (old_ack && !sd.ack) begin
						if (sd_lba >= 32'(ram_mask[23:9])) begin
							state <= snes_cart_pkg::bk_idle;
							bk_loading <= 1'b0;
						end else begin
							state <= snes_cart_pkg::bk_request;
							sd_lba <= sd_lba + 32'd1;
							sd_rd <= bk_loading;
							sd_wr <= ~bk_loading;
						end
					end
				end
			endcase
		end
	end

	// SD words go in as two byte writes, high byte on the following cycle
	assign sd_active = sd.ack && state != snes_cart_pkg::bk_idle;
	assign word_addr = {sd_lba[bsram_bits-10:0], sd.buff_addr};

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			hold_valid <= 1'b0;
		end else begin
			hold_valid <= !hold_valid && sd_active && bk_loading && sd.buff_wr;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sd.buff_wr) begin
			hold_addr <= word_addr;
			hold_data <= sd.buff_dout[15:8];
		end
	end

	always_comb begin
		sd_req = '0;
		if (hold_valid) begin
			sd_req.en = 1'b1;
			sd_req.we = 1'b1;
			sd_req.addr = 20'({hold_addr, 1'b1});
			sd_req.data = hold_data;
		end else if (sd_active && bk_loading && sd.buff_wr) begin
			sd_req.en = 1'b1;
			sd_req.we = 1'b1;
			sd_req.addr = 20'({word_addr, 1'b0});
			sd_req.data = sd.buff_dout[7:0];
		end else if (sd_active && !bk_loading) begin
			// Save reads a whole word per buffer address
			sd_req.en = 1'b1;
			sd_req.addr = 20'({word_addr, 1'b0});
		end
	end

endmodule

/* bsram_arbiter.sv */
module bsram_arbiter #(
	parameter int bsram_bits = 17
) (
	input  logic                      clk_sys,
	input  snes_cart_pkg::dl_bus_t    dl,
	input  snes_cart_pkg::bsram_req_t bsram_req,
	input  snes_cart_pkg::bsram_req_t sd_req,
	output logic [7:0]                bsram_q,
	output logic [15:0]               sd_buff_din
);

	logic [15:0] mem [2**(bsram_bits-1)];

	logic                  gnt_wipe, gnt_sd_wr, gnt_console, gnt_sd_rd;
	logic [bsram_bits-1:0] sel_addr;
	logic [7:0]            sel_data;
	logic                  sel_we;
	logic [15:0]           console_word;
	logic                  console_lane;

	// Fixed priority, a losing request is dropped
	assign gnt_wipe = dl.download & ~dl.code_index & dl.wr;
	assign gnt_sd_wr = !gnt_wipe && sd_req.en && sd_req.we;
	assign gnt_console = !gnt_wipe && !gnt_sd_wr && bsram_req.en;
	assign gnt_sd_rd = !gnt_wipe && !gnt_sd_wr && !gnt_console && sd_req.en && !sd_req.we;

	always_comb begin
		sel_addr = bsram_req.addr[bsram_bits-1:0];
		sel_data = bsram_req.data;
		sel_we = gnt_console && bsram_req.we;
		if (gnt_wipe) begin
			// Loader fills the RAM with its own address pattern
			sel_addr = dl.addr[bsram_bits-1:0];
			sel_data = dl.addr[7:0];
			sel_we = 1'b1;
		end else if (gnt_sd_wr || gnt_sd_rd) begin
			sel_addr = sd_req.addr[bsram_bits-1:0];
			sel_data = sd_req.data;
			sel_we = gnt_sd_wr;
		end
	end

	// Byte lane from address bit 0
	always_ff @(posedge clk_sys) begin
		if (sel_we && !sel_addr[0]) begin
			mem[sel_addr[bsram_bits-1:1]][7:0] <= sel_data;
		end
		if (sel_we && sel_addr[0]) begin
			mem[sel_addr[bsram_bits-1:1]][15:8] <= sel_data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (gnt_console && !bsram_req.we) begin
			console_word <= mem[sel_addr[bsram_bits-1:1]];
			console_lane <= sel_addr[0];
		end
		if (gnt_sd_rd) begin
			sd_buff_din <= mem[sel_addr[bsram_bits-1:1]];
		end
	end

	assign bsram_q = console_lane ? console_word[15:8] : console_word[7:0];

endmodule

/* snes_cart_io.sv */
module snes_cart_io #(
	parameter int bsram_bits = 17
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  snes_cart_pkg::dl_bus_t      dl,
	input  snes_cart_pkg::header_mode_e header_mode,
	input  logic                        bk_load,
	input  logic                        bk_save,
	input  logic                        autosave,
	input  logic                        osd_status,
	input  logic                        img_mounted,
	input  logic                        img_readonly,
	input  logic                        img_size_nz,
	input  snes_cart_pkg::bsram_req_t   bsram_req,
	output logic [7:0]                  bsram_q,
	input  snes_cart_pkg::sd_blk_t      sd,
	output logic [31:0]                 sd_lba,
	output logic                        sd_rd,
	output logic                        sd_wr,
	output logic [15:0]                 sd_buff_din,
	output snes_cart_pkg::cart_info_t   cart_info,
	output snes_cart_pkg::gg_code_t     gg_code,
	output logic                        bk_ena,
	output logic                        bk_pending,
	output logic                        core_reset_n,
	output logic                        led_user
);

	logic                      cart_download;
	logic                      bk_loading;
	snes_cart_pkg::bsram_req_t sd_req;

	assign cart_download = dl.download & ~dl.code_index;

	// ==============================
	// Core reset and LED
	// ==============================

	// Console is held while a cartridge or a save file streams in
	assign core_reset_n = reset & ~cart_download & ~bk_loading;
	assign led_user = cart_download | (autosave & bk_pending);

	cart_header_detect cart_header_detect_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.header_mode (header_mode),
		.cart_info   (cart_info)
	);

	cheat_code_loader cheat_code_loader_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl      (dl),
		.gg_code (gg_code)
	);

	backup_sequencer #(
		.bsram_bits (bsram_bits)
	) backup_sequencer_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dl            (dl),
		.ram_mask      (cart_info.ram_mask),
		.console_write (bsram_req.en & bsram_req.we),
		.bk_load       (bk_load),
		.bk_save       (bk_save),
		.autosave      (autosave),
		.osd_status    (osd_status),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size_nz   (img_size_nz),
		.sd            (sd),
		.sd_lba        (sd_lba),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.sd_req        (sd_req),
		.bk_ena        (bk_ena),
		.bk_pending    (bk_pending),
		.bk_loading    (bk_loading)
	);

	bsram_arbiter #(
		.bsram_bits (bsram_bits)
	) bsram_arbiter_i (
		.clk_sys     (clk_sys),
		.dl          (dl),
		.bsram_req   (bsram_req),
		.sd_req      (sd_req),
		.bsram_q     (bsram_q),
		.sd_buff_din (sd_buff_din)
	);

endmodule

/* tb_clock.sv */
module tb_clock (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// Reset low for the first two rising edges
	initial begin
		reset = 1'b0;
		repeat (2) @(posedge clk_sys);
		#10;
		reset = 1'b1;
	end

endmodule

/* tb_checker.sv */
module tb_checker #(
	parameter int bsram_bits = 17
) (
	input logic                      clk_sys,
	input logic                      reset,
	input snes_cart_pkg::cart_info_t cart_info,
	input snes_cart_pkg::gg_code_t   gg_code,
	input logic [7:0]                bsram_q,
	input logic [31:0]               sd_lba,
	input logic                      sd_rd,
	input logic                      sd_wr,
	input logic [15:0]               sd_buff_din,
	input logic                      bk_ena,
	input logic                      bk_pending,
	input logic                      core_reset_n,
	input logic                      led_user
);

	int errors = 0;
	int checks = 0;
	int test_errors = 0;
	int code_pulses = 0;

	// Byte image of the backup RAM
	logic [7:0]   model_mem [2**bsram_bits];
	logic [127:0] code_q [$];
	logic [127:0] code_exp;

	// ==============================
	// Mask rule
	// ==============================

	function automatic logic [23:0] size_mask(input logic [3:0] code);
		logic [31:0] full;
		full = (32'd1024 << code) - 32'd1;
		return full[23:0];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("%s", msg);
		errors++;
		test_errors++;
	endtask

	task automatic test_done(input string name);
		$display("test %-14s %s", name, test_errors == 0 ? "ok" : "failed");
		test_errors = 0;
	endtask

	task automatic report();
		$display("checks %0d, errors %0d", checks, errors);
	endtask

	task automatic check_header(input logic [7:0] rom_type, input logic [3:0] rom_code,
			input logic [3:0] ram_code, input logic region);
		check_value("cart_info.rom_type", cart_info.rom_type, rom_type);
		check_value("cart_info.rom_mask", cart_info.rom_mask, size_mask(rom_code));
		check_value("cart_info.ram_mask", cart_info.ram_mask,
			ram_code == 4'h0 ? 24'd0 : size_mask(ram_code));
		check_value("cart_info.region", cart_info.region, region);
	endtask

	// Loader writes the low address byte at every download address
	task automatic model_wipe(input logic [24:0] addr);
		model_mem[addr[bsram_bits-1:0]] = addr[7:0];
	endtask

	task automatic model_write(input logic [19:0] addr, input logic [7:0] data);
		model_mem[addr[bsram_bits-1:0]] = data;
	endtask

	task automatic model_word(input logic [bsram_bits-2:0] word, input logic [15:0] data);
		model_mem[{word, 1'b0}] = data[7:0];
		model_mem[{word, 1'b1}] = data[15:8];
	endtask

	task automatic check_read(input logic [19:0] addr);
		check_value("bsram_q", bsram_q, model_mem[addr[bsram_bits-1:0]]);
	endtask

	task automatic check_save_word(input logic [bsram_bits-2:0] word);
		check_value("sd_buff_din", sd_buff_din, {model_mem[{word, 1'b1}], model_mem[{word, 1'b0}]});
	endtask

	task automatic check_strobe(input logic load, input int blk);
		check_value("sd_lba", sd_lba, blk);
		check_value("sd_rd", sd_rd, load);
		check_value("sd_wr", sd_wr, !load);
	endtask

	task automatic check_idle();
		check_value("sd_rd", sd_rd, 0);
		check_value("sd_wr", sd_wr, 0);
	endtask

	task automatic check_bk_ena(input logic exp);
		check_value("bk_ena", bk_ena, exp);
	endtask

	task automatic check_pending(input logic exp);
		check_value("bk_pending", bk_pending, exp);
	endtask

	task automatic check_core_reset(input logic exp);
		check_value("core_reset_n", core_reset_n, exp);
	endtask

	task automatic check_led(input logic exp);
		check_value("led_user", led_user, exp);
	endtask

	task automatic expect_code(input logic [31:0] f, input logic [31:0] a,
			input logic [31:0] c, input logic [31:0] r);
		code_q.push_back({f, a, c, r});
	endtask

	task automatic check_code_count(input int n);
		check_value("gg_code.valid count", code_pulses, n);
		if (code_q.size() != 0) begin
			note_failure("cheat records were sent without a valid pulse");
		end
		code_pulses = 0;
	endtask

	// Cheat records are compared on the falling edge where they are stable
	always @(negedge clk_sys) begin
		if (reset && gg_code.valid) begin
			code_pulses++;
			if (code_q.size() == 0) begin
				note_failure("cheat valid pulse with no record sent");
			end else begin
				code_exp = code_q.pop_front();
				check_value("gg_code.flags", gg_code.flags, code_exp[127:96]);
				check_value("gg_code.address", gg_code.address, code_exp[95:64]);
				check_value("gg_code.compare", gg_code.compare, code_exp[63:32]);
				check_value("gg_code.replace", gg_code.replace, code_exp[31:0]);
			end
		end
	end

endmodule

/* tb_assertions.sv */
module tb_assertions (
	input logic                    clk_sys,
	input logic                    reset,
	input logic                    sd_rd,
	input logic                    sd_wr,
	input snes_cart_pkg::sd_blk_t  sd,
	input snes_cart_pkg::gg_code_t gg_code
);

	int failures = 0;

	strobes_exclusive: assert property (@(posedge clk_sys) disable iff (!reset)
		!(sd_rd && sd_wr))
	else begin
		$error("sd_rd and sd_wr high together");
		failures++;
	end

	// Valid is a single-cycle pulse
	valid_single: assert property (@(posedge clk_sys) disable iff (!reset)
		gg_code.valid |=> !gg_code.valid)
	else begin
		$error("gg_code.valid high two cycles in a row");
		failures++;
	end

	rd_drops_after_ack: assert property (@(posedge clk_sys) disable iff (!reset)
		$rose(sd.ack) |=> !sd_rd)
	else begin
		$error("sd_rd still high after ack rose");
		failures++;
	end

endmodule

bind snes_cart_io tb_assertions tb_assertions_i (
	.clk_sys (clk_sys),
	.reset   (reset),
	.sd_rd   (sd_rd),
	.sd_wr   (sd_wr),
	.sd      (sd),
	.gg_code (gg_code)
);

/* tb_snes_cart_io.sv */
module tb_snes_cart_io;

	localparam int bsram_bits = 17;
	// RAM size code 1 gives ram_mask 16'h7FF, so blocks 0 to 3
	localparam int last_block = 3;

	logic                        clk_sys;
	logic                        reset;
	snes_cart_pkg::dl_bus_t      dl;
	snes_cart_pkg::header_mode_e header_mode;
	logic                        bk_load, bk_save, autosave, osd_status;
	logic                        img_mounted, img_readonly, img_size_nz;
	snes_cart_pkg::bsram_req_t   bsram_req;
	logic [7:0]                  bsram_q;
	snes_cart_pkg::sd_blk_t      sd;
	logic [31:0]                 sd_lba;
	logic                        sd_rd, sd_wr;
	logic [15:0]                 sd_buff_din;
	snes_cart_pkg::cart_info_t   cart_info;
	snes_cart_pkg::gg_code_t     gg_code;
	logic                        bk_ena, bk_pending, core_reset_n, led_user;
	integer                      seed;

	tb_clock tb_clock_i (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	snes_cart_io #(
		.bsram_bits (bsram_bits)
	) snes_cart_io_i (.*);

	tb_checker #(
		.bsram_bits (bsram_bits)
	) tb_checker_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cart_info    (cart_info),
		.gg_code      (gg_code),
		.bsram_q      (bsram_q),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_buff_din  (sd_buff_din),
		.bk_ena       (bk_ena),
		.bk_pending   (bk_pending),
		.core_reset_n (core_reset_n),
		.led_user     (led_user)
	);

	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	// Every step ends 10 units after a rising edge
	task automatic tick();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic cart_write(input logic [24:0] addr, input logic [15:0] data);
		dl.download = 1'b1;
		dl.code_index = 1'b0;
		dl.addr = addr;
		dl.data = data;
		dl.wr = 1'b1;
		tb_checker_i.model_wipe(addr);
		tick();
		dl.wr = 1'b0;
	endtask

	task automatic code_write(input logic [24:0] addr, input logic [15:0] data);
		dl.download = 1'b1;
		dl.code_index = 1'b1;
		dl.addr = addr;
		dl.data = data;
		dl.wr = 1'b1;
		tick();
		dl.wr = 1'b0;
	endtask

	task automatic download_end();
		dl = '0;
		tick();
		tick();
	endtask

	task automatic console_write(input logic [19:0] addr, input logic [7:0] data);
		bsram_req = '{en: 1'b1, we: 1'b1, addr: addr, data: data};
		tb_checker_i.model_write(addr, data);
		tick();
		bsram_req = '0;
	endtask

	task automatic console_read(input logic [19:0] addr);
		bsram_req = '{en: 1'b1, we: 1'b0, addr: addr, data: 8'h00};
		tick();
		bsram_req = '0;
		tb_checker_i.check_read(addr);
	endtask

	task automatic wait_strobe(output bit found);
		int n;
		found = 1'b0;
		for (n = 0; n < 1000 && !found; n++) begin
			if (sd_rd || sd_wr) begin
				found = 1'b1;
			end else begin
				tick();
			end
		end
		if (!found) begin
			tb_checker_i.note_failure("SD strobe did not rise within 1000 cycles");
		end
	endtask

	// ==============================
	// SD block model
	// ==============================

	task automatic sd_blocks(input logic load);
		int  blk;
		int  i;
		bit  found;
		for (blk = 0; blk <= last_block; blk++) begin
			wait_strobe(found);
			if (!found) begin
				break;
			end
			tb_checker_i.check_strobe(load, blk);
			sd.ack = 1'b1;
			for (i = 0; i < 256; i++) begin
				sd.buff_addr = i[7:0];
				if (load) begin
					sd.buff_dout = 16'(next_random());
					sd.buff_wr = 1'b1;
					tb_checker_i.model_word({blk[7:0], i[7:0]}, sd.buff_dout);
					tick();
					sd.buff_wr = 1'b0;
					tick();
					if (i == 128) begin
						tb_checker_i.check_core_reset(1'b0);
					end
				end else begin
					// Buffer data follows the address by one cycle
					tick();
					tb_checker_i.check_save_word({blk[7:0], i[7:0]});
				end
			end
			tick();
			sd.ack = 1'b0;
			tick();
		end
		repeat (20) begin
			tick();
			tb_checker_i.check_idle();
		end
	endtask

	logic [15:0] w0, w2;
	logic [3:0]  rs, ras;
	logic [24:0] base;
	logic [31:0] f, a, c, r;
	logic [19:0] addrs [32];
	int          n, k;

	initial begin
		seed = 32'h9d67;
		dl = '0;
		header_mode = snes_cart_pkg::mode_auto;
		bk_load = 1'b0;
		bk_save = 1'b0;
		autosave = 1'b0;
		osd_status = 1'b0;
		img_mounted = 1'b1;
		img_readonly = 1'b0;
		img_size_nz = 1'b0;
		bsram_req = '0;
		sd = '0;

		n = 0;
		while (!reset && n < 20) begin
			@(posedge clk_sys);
			n++;
		end
		if (!reset) begin
			tb_checker_i.note_failure("reset was never released");
		end
		tick();

		// Auto mode, sizes and type from the prefix word
		repeat (4) begin
			w0 = 16'(next_random());
			w2 = 16'(next_random());
			cart_write(25'd0, w0);
			cart_write(25'd2, w2);
			cart_write(25'd4, 16'(next_random()));
			cart_write(25'd6, 16'(next_random()));
			download_end();
			if (w0[7:0] != 8'h00) begin
				tb_checker_i.check_header(w0[15:8], w0[3:0], w0[7:4], w2[8]);
			end else begin
				tb_checker_i.check_header(w0[15:8], 4'hC, 4'h0, w2[8]);
			end
		end
		tb_checker_i.test_done("auto header");

		for (k = 0; k < 3; k++) begin
			case (k)
				0: begin
					header_mode = snes_cart_pkg::mode_lorom;
					base = 25'(snes_cart_pkg::HDR_LOROM_SIZE);
				end
				1: begin
					header_mode = snes_cart_pkg::mode_hirom;
					base = 25'(snes_cart_pkg::HDR_HIROM_SIZE);
				end
				default: begin
					header_mode = snes_cart_pkg::mode_exhirom;
					base = 25'(snes_cart_pkg::HDR_EXHIROM_SIZE);
				end
			endcase
			base = base + 25'(snes_cart_pkg::COPIER_OFFSET);
			rs = 4'(next_random());
			ras = 4'(next_random());
			w2 = 16'(next_random());
			cart_write(25'd0, 16'(next_random()));
			cart_write(25'd2, w2);
			cart_write(base, {4'h0, rs, 8'h5A});
			cart_write(base + 25'd2, {12'h000, ras});
			cart_write(base + 25'd4, 16'h0000);
			cart_write(base + 25'd6, 16'h0000);
			download_end();
			tb_checker_i.check_header(8'(k), rs, ras, w2[8]);
		end
		header_mode = snes_cart_pkg::mode_auto;
		tb_checker_i.test_done("forced header");

		// Cheat records, eight words each after the copier prefix
		for (k = 0; k < 4; k++) begin
			f = next_random();
			a = next_random();
			c = next_random();
			r = next_random();
			tb_checker_i.expect_code(f, a, c, r);
			base = 25'(snes_cart_pkg::COPIER_OFFSET + k * 16);
			code_write(base, f[15:0]);
			code_write(base + 25'd2, f[31:16]);
			code_write(base + 25'd4, a[15:0]);
			code_write(base + 25'd6, a[31:16]);
			code_write(base + 25'd8, c[15:0]);
			code_write(base + 25'd10, c[31:16]);
			code_write(base + 25'd12, r[15:0]);
			code_write(base + 25'd14, r[31:16]);
		end
		download_end();
		tb_checker_i.check_code_count(4);
		tb_checker_i.test_done("cheat codes");

		// Every byte of the save area goes through the loader
		for (n = 0; n < 2048; n++) begin
			cart_write(25'(n), n == 0 ? 16'h0018 : 16'h0000);
		end
		tb_checker_i.check_led(1'b1);
		download_end();
		tb_checker_i.check_led(1'b0);
		tb_checker_i.check_header(8'h00, 4'h8, 4'h1, 1'b0);
		tb_checker_i.check_bk_ena(1'b1);
		repeat (16) begin
			console_read(20'(next_random() & 32'h7FF));
		end
		for (k = 0; k < 32; k++) begin
			addrs[k] = 20'(next_random() & 32'h7FF);
			console_write(addrs[k], 8'(next_random()));
		end
		for (k = 0; k < 32; k++) begin
			console_read(addrs[k]);
		end
		tb_checker_i.test_done("console access");

		tb_checker_i.check_pending(1'b1);
		// Pending save shows on the LED once autosave is on
		autosave = 1'b1;
		tick();
		tb_checker_i.check_led(1'b1);
		bk_save = 1'b1;
		tick();
		bk_save = 1'b0;
		sd_blocks(1'b0);
		tb_checker_i.check_pending(1'b0);
		tb_checker_i.check_led(1'b0);
		tb_checker_i.test_done("save");

		bk_load = 1'b1;
		tick();
		bk_load = 1'b0;
		sd_blocks(1'b1);
		tb_checker_i.check_core_reset(1'b1);
		repeat (32) begin
			console_read(20'(next_random() & 32'h7FF));
		end
		tb_checker_i.test_done("load");

		tb_checker_i.report();
		if (tb_checker_i.errors == 0 && snes_cart_io_i.tb_assertions_i.failures == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* sim.f */
snes_cart_pkg.sv
cart_header_detect.sv
cheat_code_loader.sv
backup_sequencer.sv
bsram_arbiter.sv
snes_cart_io.sv
tb_clock.sv
tb_checker.sv
tb_assertions.sv
tb_snes_cart_io.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_snes_cart_io -f sim.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^TESTBENCH PASSED$"; then
	exit 0
fi
exit 1
